// ==== bench/dcache_golden.txt ====
# columns: op (R read, W write, H halt, M memory image check), address,
# store data, expected value, memory reads, memory writes (all hex)
# read miss in set 1, then hits on both words
R 0000010c 00000000 5a5a010c 2 0
R 00000108 00000000 5a5a0108 0 0
R 0000010c 00000000 5a5a010c 0 0
# write hit and read back
W 00000108 11110108 00000000 0 0
R 00000108 00000000 11110108 0 0
# write miss in set 2
W 00000210 22220210 00000000 2 0
R 00000214 00000000 5a5a0214 0 0
R 00000210 00000000 22220210 0 0
# tag B into way 1, touch A, tag C evicts dirty B
W 0000014c 3333014c 00000000 2 0
R 00000108 00000000 11110108 0 0
R 00000188 00000000 5a5a0188 2 2
R 0000010c 00000000 5a5a010c 0 0
# B comes back from memory with its written word
R 0000014c 00000000 3333014c 2 0
W 00000148 44440148 00000000 0 0
# flush writes three dirty lines
H 00000000 00000000 00000000 0 6
M 00000108 00000000 11110108 0 0
M 0000010c 00000000 5a5a010c 0 0
M 00000148 00000000 44440148 0 0
M 0000014c 00000000 3333014c 0 0
M 00000188 00000000 5a5a0188 0 0
M 0000018c 00000000 5a5a018c 0 0
M 00000210 00000000 22220210 0 0
M 00000214 00000000 5a5a0214 0 0
M 00000300 00000000 5a5a0300 0 0

// ==== dcache.f ====
logic/dcache_pkg.sv
logic/dcache_frame_if.sv
logic/dcache_frames.sv
logic/dcache_ctrl.sv
logic/dcache.sv
bench/tb_clock.sv
bench/dcache_tb.sv

// ==== Bender.yml ====
package:
  name: dcache

sources:
  - logic/dcache_pkg.sv
  - logic/dcache_frame_if.sv
  - logic/dcache_frames.sv
  - logic/dcache_ctrl.sv
  - logic/dcache.sv
  - target: test
    files:
      - bench/tb_clock.sv
      - bench/dcache_tb.sv

// ==== bench/dcache_tb.sv ====
// ==========================================================
// data cache testbench
// memory model with random wait, golden file reader,
// compare tasks, access and halt sequences
// ==========================================================

`timescale 1ns/1ps
`default_nettype none

module dcache_tb
    import dcache_pkg::*;
;

    localparam int          TIMEOUT     = 200;
    localparam int          DRIVE_DLY   = 2;
    localparam int          WAIT_MAX    = 3;
    localparam int          HOLD_CYCLES = 4;
    localparam logic [31:0] SEED        = 32'hac7ce522;
    localparam string       GOLDEN      = "bench/dcache_golden.txt";

    logic  CLK;
    logic  nRST;
    logic  dmem_ren;
    logic  dmem_wen;
    word_t dmem_addr;
    word_t dmem_store;
    logic  halt;
    word_t dmem_load;
    logic  dhit;
    logic  flushed;
    logic  mem_ren;
    logic  mem_wen;
    word_t mem_addr;
    word_t mem_store;
    word_t mem_load;
    logic  mem_wait;

    // memory model state
    word_t       mem [word_t];
    int unsigned mem_reads;
    int unsigned mem_writes;
    int unsigned wait_left;
    logic        in_xfer;
    integer      seed;

    tb_clock u_clock (
        .CLK (CLK)
    );

    dcache u_dcache (
        .CLK        (CLK),
        .nRST       (nRST),
        .dmem_ren   (dmem_ren),
        .dmem_wen   (dmem_wen),
        .dmem_addr  (dmem_addr),
        .dmem_store (dmem_store),
        .halt       (halt),
        .dmem_load  (dmem_load),
        .dhit       (dhit),
        .flushed    (flushed),
        .mem_ren    (mem_ren),
        .mem_wen    (mem_wen),
        .mem_addr   (mem_addr),
        .mem_store  (mem_store),
        .mem_load   (mem_load),
        .mem_wait   (mem_wait)
    );

    // unwritten words follow the address pattern
    function automatic word_t mem_peek(input word_t a);
        if (mem.exists(a)) begin
            return mem[a];
        end
        return a ^ 32'h5a5a0000;
    endfunction

    // new transfer draws its wait, then counts down
    always @(posedge CLK) begin
        #DRIVE_DLY;
        if (mem_ren || mem_wen) begin
            if (!in_xfer) begin
                in_xfer   = 1'b1;
                wait_left = $unsigned($random(seed)) % (WAIT_MAX + 1);
            end else if (wait_left != 0) begin
                wait_left--;
            end
        end
        mem_wait = in_xfer && (wait_left != 0);
        mem_load = mem_peek(mem_addr);
    end

    // transfer completes at the coming edge
    always @(negedge CLK) begin
        if (in_xfer && !mem_wait) begin
            if (mem_wen) begin
                mem[mem_addr] = mem_store;
                mem_writes++;
            end
            if (mem_ren) begin
                mem_reads++;
            end
            in_xfer = 1'b0;
        end
    end

    task automatic fail();
        $display("tests failed");
        $fatal(1, "stopped at first failure");
    endtask

    task automatic check_word(input string name, input word_t exp, input word_t act);
        if (act !== exp) begin
            $display("ERROR %s: expected %h, actual %h", name, exp, act);
            fail();
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("ERROR %s: expected %b, actual %b", name, exp, act);
            fail();
        end
    endtask

    // starts and ends just after a rising edge
    task automatic access_cache(input string name, input logic is_wr, input word_t addr,
                                input word_t data, input word_t exp, input word_t nrd,
                                input word_t nwr);
        int unsigned   rd0;
        int unsigned   wr0;
        int            cycles;
        logic          first_hit;
        dcache_state_t st;
        rd0        = mem_reads;
        wr0        = mem_writes;
        dmem_ren   = !is_wr;
        dmem_wen   = is_wr;
        dmem_addr  = addr;
        dmem_store = data;
        cycles     = 0;
        @(negedge CLK);
        first_hit = dhit;
        while (!dhit) begin
            if (cycles >= TIMEOUT) begin
                st = u_dcache.u_ctrl.state;
                $display("timeout: no dhit for %s after %0d cycles, controller in %s",
                         name, cycles, st.name());
                fail();
            end
            cycles++;
            @(negedge CLK);
        end
        // an access with no memory traffic answers in its own cycle
        check_flag({name, " dhit at request"}, (nrd == 0) && (nwr == 0), first_hit);
        if (!is_wr) begin
            check_word(name, exp, dmem_load);
        end
        check_word({name, " mem reads"}, nrd, word_t'(mem_reads - rd0));
        check_word({name, " mem writes"}, nwr, word_t'(mem_writes - wr0));
        @(posedge CLK);
        #DRIVE_DLY;
        dmem_ren = 1'b0;
        dmem_wen = 1'b0;
    endtask

    task automatic halt_and_flush(input string name, input word_t nwr);
        int unsigned   wr0;
        int            cycles;
        dcache_state_t st;
        wr0    = mem_writes;
        halt   = 1'b1;
        cycles = 0;
        @(negedge CLK);
        while (!flushed) begin
            if (cycles >= TIMEOUT) begin
                st = u_dcache.u_ctrl.state;
                $display("timeout: flushed never rose for %s, controller in %s",
                         name, st.name());
                fail();
            end
            cycles++;
            @(negedge CLK);
        end
        check_word({name, " mem writes"}, nwr, word_t'(mem_writes - wr0));
        for (int i = 0; i < HOLD_CYCLES; i++) begin
            @(negedge CLK);
            check_flag({name, " flushed held"}, 1'b1, flushed);
        end
    endtask

    initial begin
        int    fd;
        int    c;
        int    n;
        int    op_num;
        word_t addr;
        word_t data;
        word_t exp;
        word_t nrd;
        word_t nwr;
        string name;
        seed       = SEED;
        nRST       = 1'b0;
        dmem_ren   = 1'b0;
        dmem_wen   = 1'b0;
        dmem_addr  = '0;
        dmem_store = '0;
        halt       = 1'b0;
        mem_load   = '0;
        mem_wait   = 1'b0;
        mem_reads  = 0;
        mem_writes = 0;
        wait_left  = 0;
        in_xfer    = 1'b0;
        repeat (5) @(posedge CLK);
        #DRIVE_DLY;
        nRST = 1'b1;
        @(negedge CLK);
        check_flag("reset dhit", 1'b0, dhit);
        check_flag("reset mem_ren", 1'b0, mem_ren);
        check_flag("reset mem_wen", 1'b0, mem_wen);
        check_flag("reset flushed", 1'b0, flushed);
        @(posedge CLK);
        #DRIVE_DLY;

        fd = $fopen(GOLDEN, "r");
        if (fd == 0) begin
            $display("cannot open golden file %s", GOLDEN);
            fail();
        end
        op_num = 0;
        c      = $fgetc(fd);
        while (c != -1) begin
            if (c == "#") begin
                while (c != -1 && c != "\n") begin
                    c = $fgetc(fd);
                end
            end else if (c == "R" || c == "W" || c == "H" || c == "M") begin
                n = $fscanf(fd, " %h %h %h %h %h", addr, data, exp, nrd, nwr);
                if (n != 5) begin
                    $display("golden line after op %0d is malformed", op_num);
                    fail();
                end
                op_num++;
                name = $sformatf("op %0d %c %h", op_num, c, addr);
                case (c)
                    "R": access_cache(name, 1'b0, addr, data, exp, nrd, nwr);
                    "W": access_cache(name, 1'b1, addr, data, exp, nrd, nwr);
                    "H": halt_and_flush(name, nwr);
                    default: check_word(name, exp, mem_peek(addr));
                endcase
            end
            c = $fgetc(fd);
        end
        $fclose(fd);

        if (op_num == 0) begin
            $display("golden file held no operations");
            $display("tests failed");
            $fatal(1, "empty stimulus");
        end else begin
            $display("all tests passed");
            $finish;
        end
    end

endmodule

`default_nettype wire

// ==== bench/tb_clock.sv ====
// ==========================================================
// testbench clock generator, 40 ns period
// ==========================================================

`timescale 1ns/1ps
`default_nettype none

module tb_clock (
    output logic CLK
);

    localparam int PERIOD = 40;

    initial begin
        CLK = 1'b0;
    end

    always #(PERIOD / 2) CLK = ~CLK;

endmodule

`default_nettype wire

// ==== logic/dcache.sv ====
// ==========================================================
// two-way set-associative write-back data cache
// processor and memory ports, controller and frame store
// ==========================================================

`timescale 1ns/1ps
`default_nettype none

module dcache
    import dcache_pkg::*;
(
    input  logic  CLK,
    input  logic  nRST,
    // processor side
    input  logic  dmem_ren,
    input  logic  dmem_wen,
    input  word_t dmem_addr,
    input  word_t dmem_store,
    input  logic  halt,
    output word_t dmem_load,
    output logic  dhit,
    output logic  flushed,
    // memory side
    output logic  mem_ren,
    output logic  mem_wen,
    output word_t mem_addr,
    output word_t mem_store,
    input  word_t mem_load,
    input  logic  mem_wait
);

    dcache_frame_if fif ();

    dcache_frames u_frames (
        .CLK  (CLK),
        .nRST (nRST),
        .fif  (fif.frames)
    );

    dcache_ctrl u_ctrl (
        .CLK        (CLK),
        .nRST       (nRST),
        .dmem_ren   (dmem_ren),
        .dmem_wen   (dmem_wen),
        .dmem_addr  (dmem_addr),
        .dmem_store (dmem_store),
        .halt       (halt),
        .dmem_load  (dmem_load),
        .dhit       (dhit),
        .flushed    (flushed),
        .mem_ren    (mem_ren),
        .mem_wen    (mem_wen),
        .mem_addr   (mem_addr),
        .mem_store  (mem_store),
        .mem_load   (mem_load),
        .mem_wait   (mem_wait),
        .fif        (fif.ctrl)
    );

endmodule

`default_nettype wire

// ==== logic/dcache_ctrl.sv ====
// ==========================================================
// data cache controller
// FSM for hits, victim write-back, line fill and flush
// memory port outputs and the flush step counter
// ==========================================================

`timescale 1ns/1ps
`default_nettype none

module dcache_ctrl
    import dcache_pkg::*;
(
    input  logic         CLK,
    input  logic         nRST,
    input  logic         dmem_ren,
    input  logic         dmem_wen,
    input  word_t        dmem_addr,
    input  word_t        dmem_store,
    input  logic         halt,
    output word_t        dmem_load,
    output logic         dhit,
    output logic         flushed,
    output logic         mem_ren,
    output logic         mem_wen,
    output word_t        mem_addr,
    output word_t        mem_store,
    input  word_t        mem_load,
    input  logic         mem_wait,
    dcache_frame_if.ctrl fif
);

    dcache_state_t state;
    dcache_state_t next_state;

    logic [$clog2(FLUSH_STEPS)-1:0] flush_cnt;
    logic                           flush_step;
    logic                           flush_last;

    logic         req;
    dcache_addr_u req_a;
    dcache_addr_u mem_a;

    assign req   = dmem_ren || dmem_wen;
    assign req_a = dcache_addr_u'(dmem_addr);

    assign fif.lookup     = req_a;
    assign fif.lookup_en  = (state == IDLE) && req;
    assign fif.wr_data    = dmem_store;
    assign fif.fill_data  = mem_load;
    assign fif.fill_dirty = dmem_wen;
    assign fif.flush_sel  = flush_cnt;

    assign dmem_load = fif.rd_data;

    // clean words take one cycle, dirty ones wait for the write
    assign flush_step = (state == FLUSH) && (!fif.flush_dirty || !mem_wait);
    // all ones is the last frame word
    assign flush_last = &flush_cnt;

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            state     <= IDLE;
            flush_cnt <= '0;
        end else begin
            state <= next_state;
            if (flush_step && !flush_last) begin
                flush_cnt <= flush_cnt + 1'b1;
            end
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            IDLE: begin
                if (req) begin
                    if (!fif.hit) begin
                        next_state = fif.victim_dirty ? WB0 : FILL0;
                    end
                end else if (halt) begin
                    next_state = FLUSH;
                end
            end
            WB0: begin
                if (!mem_wait) begin
                    next_state = WB1;
                end
            end
            WB1: begin
                if (!mem_wait) begin
                    next_state = FILL0;
                end
            end
            FILL0: begin
                if (!mem_wait) begin
                    next_state = FILL1;
                end
            end
            FILL1: begin
                // request hits once back in IDLE
                if (!mem_wait) begin
                    next_state = IDLE;
                end
            end
            FLUSH: begin
                if (flush_step && flush_last) begin
                    next_state = FLUSHED;
                end
            end
            FLUSHED: begin
                next_state = FLUSHED;
            end
            default: begin
                next_state = IDLE;
            end
        endcase
    end

    always_comb begin
        mem_a           = '0;
        mem_ren         = 1'b0;
        mem_wen         = 1'b0;
        mem_store       = '0;
        dhit            = 1'b0;
        flushed         = 1'b0;
        fif.wr_en       = 1'b0;
        fif.fill_en     = 1'b0;
        fif.fill_word   = 1'b0;
        fif.clean_en    = 1'b0;
        fif.flush_clean = 1'b0;
        case (state)
            IDLE: begin
                dhit      = fif.hit;
                fif.wr_en = fif.hit && dmem_wen;
            end
            WB0, WB1: begin
                mem_wen      = 1'b1;
                mem_a.f.tag  = fif.victim_tag;
                mem_a.f.idx  = req_a.f.idx;
                mem_a.f.blkoff = (state == WB1);
                mem_store    = fif.victim_data[state == WB1];
                fif.clean_en = (state == WB1) && !mem_wait;
            end
            FILL0, FILL1: begin
                // line base from the request, word from the state
                mem_ren        = 1'b1;
                mem_a.f.tag    = req_a.f.tag;
                mem_a.f.idx    = req_a.f.idx;
                mem_a.f.blkoff = (state == FILL1);
                fif.fill_en    = !mem_wait;
                fif.fill_word  = (state == FILL1);
            end
            FLUSH: begin
                mem_wen         = fif.flush_dirty;
                mem_a.f.tag     = fif.flush_tag;
                mem_a.f.idx     = flush_cnt[IDX_W:1];
                mem_a.f.blkoff  = flush_cnt[0];
                mem_store       = fif.flush_word;
                fif.flush_clean = fif.flush_dirty && !mem_wait;
            end
            FLUSHED: begin
                flushed = 1'b1;
            end
            default: begin
                flushed = 1'b0;
            end
        endcase
        mem_addr = mem_a.raw;
    end

endmodule

`default_nettype wire

// ==== logic/dcache_frames.sv ====
// ==========================================================
// data cache frame store
// valid, dirty, tag, data and LRU arrays
// tag compare for both ways, victim and flush read ports
// ==========================================================

`timescale 1ns/1ps
`default_nettype none

module dcache_frames
    import dcache_pkg::*;
(
    input  logic           CLK,
    input  logic           nRST,
    dcache_frame_if.frames fif
);

    logic [SETS-1:0][WAYS-1:0] valid;
    logic [SETS-1:0][WAYS-1:0] dirty;
    logic [SETS-1:0]           lru;

    logic [TAG_W-1:0] tags [SETS][WAYS];
    word_t            data [SETS][WAYS][BLOCK_WORDS];

    logic [IDX_W-1:0] idx;
    logic [WAYS-1:0]  way_hit;
    logic             hit_way;
    logic             victim;

    logic [IDX_W-1:0] fsel_idx;
    logic             fsel_way;
    logic             fsel_word;

    assign idx = fif.lookup.f.idx;

    // tag compare against both ways of the set
    always_comb begin
        for (int w = 0; w < WAYS; w++) begin
            way_hit[w] = valid[idx][w] && (tags[idx][w] == fif.lookup.f.tag);
        end
    end

    assign hit_way = way_hit[1];
    assign victim  = lru[idx];

    assign fif.hit     = fif.lookup_en && (|way_hit);
    assign fif.rd_data = data[idx][hit_way][fif.lookup.f.blkoff];

    // victim is the LRU way of the request set
    assign fif.victim_dirty   = valid[idx][victim] && dirty[idx][victim];
    assign fif.victim_tag     = tags[idx][victim];
    assign fif.victim_data[0] = data[idx][victim][0];
    assign fif.victim_data[1] = data[idx][victim][1];

    // flush step decodes as way, set, word
    assign fsel_way  = fif.flush_sel[IDX_W+1];
    assign fsel_idx  = fif.flush_sel[IDX_W:1];
    assign fsel_word = fif.flush_sel[0];

    assign fif.flush_dirty = valid[fsel_idx][fsel_way] && dirty[fsel_idx][fsel_way];
    assign fif.flush_tag   = tags[fsel_idx][fsel_way];
    assign fif.flush_word  = data[fsel_idx][fsel_way][fsel_word];

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            valid <= '0;
            dirty <= '0;
            lru   <= '0;
        end else begin
            if (fif.hit) begin
                lru[idx] <= ~hit_way;
            end
            if (fif.wr_en) begin
                dirty[idx][hit_way] <= 1'b1;
            end
            if (fif.fill_en) begin
                if (fif.fill_word) begin
                    valid[idx][victim] <= 1'b1;
                    dirty[idx][victim] <= fif.fill_dirty;
                    lru[idx]           <= ~victim;
                end else begin
                    // old line is gone once its first word is overwritten
                    valid[idx][victim] <= 1'b0;
                end
            end
            if (fif.clean_en) begin
                dirty[idx][victim] <= 1'b0;
            end
            // line is clean only after its second word went out
            if (fif.flush_clean && fsel_word) begin
                dirty[fsel_idx][fsel_way] <= 1'b0;
            end
        end
    end

    always_ff @(posedge CLK) begin
        if (fif.wr_en) begin
            data[idx][hit_way][fif.lookup.f.blkoff] <= fif.wr_data;
        end
        if (fif.fill_en) begin
            tags[idx][victim]                <= fif.lookup.f.tag;
            data[idx][victim][fif.fill_word] <= fif.fill_data;
        end
    end

endmodule

`default_nettype wire

// ==== logic/dcache_frame_if.sv ====
// ==========================================================
// controller to frame store interface
// lookup, hit write, line fill, victim clean and flush
// ==========================================================

`timescale 1ns/1ps
`default_nettype none

interface dcache_frame_if
    import dcache_pkg::*;
();

    // driven by the controller
    dcache_addr_u                   lookup;
    logic                           lookup_en;
    logic                           wr_en;
    word_t                          wr_data;
    logic                           fill_en;
    logic                           fill_word;
    word_t                          fill_data;
    logic                           fill_dirty;
    logic                           clean_en;
    logic [$clog2(FLUSH_STEPS)-1:0] flush_sel;
    logic                           flush_clean;

    // driven by the frame store
    logic                           hit;
    word_t                          rd_data;
    logic                           victim_dirty;
    logic [TAG_W-1:0]               victim_tag;
    word_t [BLOCK_WORDS-1:0]        victim_data;
    logic                           flush_dirty;
    logic [TAG_W-1:0]               flush_tag;
    word_t                          flush_word;

    modport ctrl (
        output lookup, lookup_en, wr_en, wr_data, fill_en, fill_word, fill_data,
        output fill_dirty, clean_en, flush_sel, flush_clean,
        input  hit, rd_data, victim_dirty, victim_tag, victim_data,
        input  flush_dirty, flush_tag, flush_word
    );

    modport frames (
        input  lookup, lookup_en, wr_en, wr_data, fill_en, fill_word, fill_data,
        input  fill_dirty, clean_en, flush_sel, flush_clean,
        output hit, rd_data, victim_dirty, victim_tag, victim_data,
        output flush_dirty, flush_tag, flush_word
    );

endinterface

`default_nettype wire

// ==== logic/dcache_pkg.sv ====
// ==========================================================
// data cache shared definitions
// geometry localparams, word type, address decode union
// and the controller state encoding
// ==========================================================

`default_nettype none

package dcache_pkg;

    // geometry
    localparam int WORD_W      = 32;
    localparam int SETS        = 8;
    localparam int WAYS        = 2;
    localparam int BLOCK_WORDS = 2;
    localparam int IDX_W       = 3;
    localparam int TAG_W       = 26;

    // one flush step per frame word, ways x sets x words
    localparam int FLUSH_STEPS = 32;

    typedef logic [WORD_W-1:0] word_t;

    typedef struct packed {
        logic [TAG_W-1:0] tag;
        logic [IDX_W-1:0] idx;
        logic             blkoff;
        logic [1:0]       bytoff;
    } dcache_addr_t;

    // same address word, raw or split into cache fields
    typedef union packed {
        word_t        raw;
        dcache_addr_t f;
    } dcache_addr_u;

    typedef enum logic [2:0] {
        IDLE,
        WB0,
        WB1,
        FILL0,
        FILL1,
        FLUSH,
        FLUSHED
    } dcache_state_t;

endpackage

`default_nettype wire
